// File: all.f
rv_isa_pkg.sv
core_ctrl_pkg.sv
core_stage_if.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
flint_core.sv
tb_flint_core.sv

// File: Makefile
# Verilator build for the flint_core testbench

VERILATOR ?= verilator
TOP       ?= tb_flint_core
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_flint_core.sv
/* Testbench for flint_core: program and expected-store tables,
   instruction and data memory models, random stalls and checks */
`default_nettype none

module tb_flint_core;
    import rv_isa_pkg::*;

    localparam word_t PC_START = 32'h0000_0000;

    logic  i_clk = 1'b0;
    logic  i_reset;
    word_t i_instr;
    logic  i_if_valid;
    word_t o_pc;
    word_t o_data_addr;
    word_t o_data_out;
    logic  o_store_req;
    logic  o_load_req;
    word_t i_data_in;
    logic  i_mem_valid;

    word_t prog [64];
    int    n_prog;
    word_t exp_addr [16];
    word_t exp_data [16];
    string exp_name [16];
    int    n_st;
    int    st_idx;
    word_t dmem [128];
    int    seed;
    int    cycles;
    int    limit;
    int    rst_cycles;
    int    wait_left;
    logic  load_busy;

    flint_core #(
        .PC_START (PC_START)
    ) i_flint_core (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_instr     (i_instr),
        .i_if_valid  (i_if_valid),
        .o_pc        (o_pc),
        .o_data_addr (o_data_addr),
        .o_data_out  (o_data_out),
        .o_store_req (o_store_req),
        .o_load_req  (o_load_req),
        .i_data_in   (i_data_in),
        .i_mem_valid (i_mem_valid)
    );

    always #50 i_clk = ~i_clk;

    // One encoder per RV32I instruction format
    function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        r_type = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input int imm, input int rs1, input int f3,
                                     input int rd, input int op);
        i_type = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(input int imm, input int rs2, input int rs1);
        s_type = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
        b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                  7'b1100011};
    endfunction

    function automatic word_t j_type(input int imm, input int rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t fill_word(input int idx);
        fill_word = 32'h3c00_0000 + idx * 32'h0001_0101;
    endfunction

    task automatic put(input word_t w);
        prog[n_prog] = w;
        n_prog++;
    endtask

    task automatic expect_store(input string name, input word_t addr, input word_t data);
        exp_name[n_st] = name;
        exp_addr[n_st] = addr;
        exp_data[n_st] = data;
        n_st++;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    initial begin
        i_reset = 1'b1;
        i_instr = NOP_INSTR;
        i_if_valid = 1'b1;
        i_data_in = '0;
        i_mem_valid = 1'b0;
        seed = 32'h07f7_4dba;
        n_prog = 0;
        n_st = 0;
        st_idx = 0;
        cycles = 0;
        rst_cycles = 0;
        load_busy = 1'b0;
        wait_left = 0;
        for (int i = 0; i < 64; i++) prog[i] = NOP_INSTR;
        for (int i = 0; i < 128; i++) dmem[i] = fill_word(i);

        // Dependent ALU chain
        put(i_type(5, 0, 0, 1, 7'b0010011));
        put(i_type(7, 0, 0, 2, 7'b0010011));
        put(r_type(0, 2, 1, 0, 3));
        put(s_type(256, 3, 0));
        put(r_type(32, 1, 3, 0, 4));
        put(r_type(0, 4, 3, 7, 5));
        put(r_type(0, 4, 3, 6, 6));
        put(r_type(0, 1, 6, 4, 7));
        put(r_type(0, 3, 4, 2, 8));
        put({20'h12345, 5'd9, 7'b0110111});
        for (int r = 4; r <= 9; r++) put(s_type(244 + 4 * r, r, 0));
        // Load then immediate use
        put(i_type(64, 0, 2, 10, 7'b0000011));
        put(i_type(3, 10, 0, 11, 7'b0010011));
        put(s_type(284, 11, 0));
        // Write to x0
        put(i_type(99, 0, 0, 0, 7'b0010011));
        put(s_type(288, 0, 0));
        // Branches and jumps with wrong-path stores in between
        put(b_type(12, 1, 1, 0));
        put(s_type(292, 1, 0));
        put(s_type(292, 2, 0));
        put(b_type(8, 1, 1, 1));
        put(s_type(292, 2, 0));
        put(j_type(12, 12));
        put(s_type(296, 1, 0));
        put(s_type(296, 1, 0));
        put(s_type(296, 12, 0));
        put(i_type(136, 0, 0, 13, 7'b0010011));
        put(i_type(4, 13, 0, 14, 7'b1100111));
        put(s_type(300, 1, 0));
        put(s_type(300, 1, 0));
        put(s_type(300, 1, 0));
        put(s_type(300, 14, 0));

        expect_store("add", 32'h100, 32'd5 + 32'd7);
        expect_store("sub", 32'h104, 32'd12 - 32'd5);
        expect_store("and", 32'h108, 32'd12 & 32'd7);
        expect_store("or", 32'h10c, 32'd12 | 32'd7);
        expect_store("xor", 32'h110, 32'd15 ^ 32'd5);
        expect_store("slt", 32'h114, 32'd1);
        expect_store("lui", 32'h118, 32'h1234_5000);
        expect_store("load_use", 32'h11c, fill_word(16) + 32'd3);
        expect_store("x0_write", 32'h120, 32'd0);
        expect_store("beq_bne", 32'h124, 32'd7);
        expect_store("jal_link", 32'h128, 32'd104 + 32'd4);
        expect_store("jalr_link", 32'h12c, 32'd124 + 32'd4);
        limit = n_prog * 8 + 50;
    end

    always @(negedge i_clk) begin
        i_instr = prog[o_pc[7:2]];
        if (i_reset) begin
            rst_cycles++;
            if (rst_cycles == 3) begin
                check_word("reset_pc", PC_START, o_pc);
                check_bit("reset_store_req", 1'b0, o_store_req);
                check_bit("reset_load_req", 1'b0, o_load_req);
                i_reset = 1'b0;
            end
        end else begin
            cycles++;
            if (cycles <= 5) begin
                check_bit("early_store_req", 1'b0, o_store_req);
                check_bit("early_load_req", 1'b0, o_load_req);
            end
            if (o_store_req && st_idx >= n_st) begin
                $display("Store to %h with no entry left in the expected table", o_data_addr);
                $display("Testbench failed");
                $fatal(1);
            end else if (o_store_req) begin
                check_word({exp_name[st_idx], " addr"}, exp_addr[st_idx], o_data_addr);
                check_word({exp_name[st_idx], " data"}, exp_data[st_idx], o_data_out);
                dmem[o_data_addr[8:2]] = o_data_out;
                st_idx++;
            end
            // Load answer after 0 to 3 wait cycles
            i_mem_valid = 1'b0;
            if (o_load_req) begin
                if (!load_busy) begin
                    load_busy = 1'b1;
                    wait_left = $random(seed) & 3;
                end
                if (wait_left == 0) begin
                    i_mem_valid = 1'b1;
                    i_data_in = dmem[o_data_addr[8:2]];
                    load_busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end
            // Single-cycle fetch gaps
            i_if_valid = !i_if_valid ? 1'b1 : (($random(seed) & 7) != 0);
            if (st_idx == n_st) begin
                $display("Testbench passed");
                $finish;
            end else if (cycles > limit) begin
                $display("Timeout after %0d cycles with %0d stores seen", cycles, st_idx);
                $display("Testbench failed");
                $fatal(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: flint_core.sv
/* Four-stage RV32I core top level */
`default_nettype none

module flint_core #(
    parameter rv_isa_pkg::word_t PC_START   = '0,
    parameter int                REG_ADDR_W = 5
) (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire rv_isa_pkg::word_t i_instr,
    input  wire logic              i_if_valid,
    output rv_isa_pkg::word_t      o_pc,
    output rv_isa_pkg::word_t      o_data_addr,
    output rv_isa_pkg::word_t      o_data_out,
    output logic                   o_store_req,
    output logic                   o_load_req,
    input  wire rv_isa_pkg::word_t i_data_in,
    input  wire logic              i_mem_valid
);

    exec_bus_if ex_bus ();
    mem_bus_if  mem_bus ();
    wb_fwd_if   fwd_bus ();

    decode_stage #(
        .PC_START   (PC_START),
        .REG_ADDR_W (REG_ADDR_W)
    ) u_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_instr    (i_instr),
        .i_if_valid (i_if_valid),
        .o_pc       (o_pc),
        .ex         (ex_bus.producer),
        .fb         (fwd_bus.decode)
    );

    execute_stage #(
        .REG_ADDR_W (REG_ADDR_W)
    ) u_execute (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .ex      (ex_bus.consumer),
        .mb      (mem_bus.producer),
        .fb      (fwd_bus.execute)
    );

    mem_wb_stage u_mem_wb (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .mb          (mem_bus.consumer),
        .fb          (fwd_bus.mem),
        .o_data_addr (o_data_addr),
        .o_data_out  (o_data_out),
        .o_store_req (o_store_req),
        .o_load_req  (o_load_req),
        .i_data_in   (i_data_in),
        .i_mem_valid (i_mem_valid)
    );

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
/* Memory and writeback: data memory request, load wait,
   branch redirect and writeback select */
`default_nettype none

module mem_wb_stage (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    mem_bus_if.consumer            mb,
    wb_fwd_if.mem                  fb,
    output rv_isa_pkg::word_t      o_data_addr,
    output rv_isa_pkg::word_t      o_data_out,
    output logic                   o_store_req,
    output logic                   o_load_req,
    input  wire rv_isa_pkg::word_t i_data_in,
    input  wire logic              i_mem_valid
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic      wb_reg_w_q;
    logic      wb_mem2reg_q;
    reg_addr_t wb_rd_q;
    word_t     wb_alu_q;
    word_t     wb_load_q;

    assign o_data_addr = mb.alu_out;
    assign o_data_out  = mb.store_val;
    assign o_store_req = mb.ctrl.mem_w;
    assign o_load_req  = mb.ctrl.mem2reg;

    assign fb.mem_stall   = o_load_req && !i_mem_valid;
    assign fb.redirect    = mb.ctrl.jmp || mb.take;
    assign fb.redirect_pc = mb.jump_addr;
    assign fb.mem_reg_w   = mb.ctrl.reg_w;
    assign fb.mem_rd      = mb.rd_addr;
    assign fb.mem_alu_out = mb.alu_out;

    // Bubble into writeback while the load waits
    always_ff @(posedge i_clk) begin
        if (i_reset || fb.mem_stall) begin
            wb_reg_w_q   <= 1'b0;
            wb_mem2reg_q <= 1'b0;
        end else begin
            wb_reg_w_q   <= mb.ctrl.reg_w;
            wb_mem2reg_q <= mb.ctrl.mem2reg;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_rd_q   <= mb.rd_addr;
        wb_alu_q  <= mb.alu_out;
        wb_load_q <= i_data_in;
    end

    assign fb.wb_reg_w  = wb_reg_w_q;
    assign fb.wb_rd     = wb_rd_q;
    assign fb.wb_result = wb_mem2reg_q ? wb_load_q : wb_alu_q;

endmodule

`default_nettype wire

// File: execute_stage.sv
/* Execute: operand forwarding, ALU, branch compare and jump target,
   registered into the memory stage */
`default_nettype none

module execute_stage #(
    parameter int REG_ADDR_W = 5
) (
    input  wire logic    i_clk,
    input  wire logic    i_reset,
    exec_bus_if.consumer ex,
    mem_bus_if.producer  mb,
    wb_fwd_if.execute    fb
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [REG_ADDR_W-1:0] mem_idx;
    logic [REG_ADDR_W-1:0] wb_idx;
    word_t                 rs1_fwd;
    word_t                 rs2_fwd;
    word_t                 op_a;
    word_t                 op_b;
    word_t                 alu_res;
    word_t                 target_sum;
    word_t                 jump_addr;
    logic                  take;

    assign rs1_idx = ex.rs1_addr[REG_ADDR_W-1:0];
    assign rs2_idx = ex.rs2_addr[REG_ADDR_W-1:0];
    assign mem_idx = fb.mem_rd[REG_ADDR_W-1:0];
    assign wb_idx  = fb.wb_rd[REG_ADDR_W-1:0];

    // Memory stage is younger, so it wins
    assign rs1_fwd = (fb.mem_reg_w && mem_idx == rs1_idx) ? fb.mem_alu_out :
                     (fb.wb_reg_w && wb_idx == rs1_idx)   ? fb.wb_result   :
                                                            ex.rs1_val;
    assign rs2_fwd = (fb.mem_reg_w && mem_idx == rs2_idx) ? fb.mem_alu_out :
                     (fb.wb_reg_w && wb_idx == rs2_idx)   ? fb.wb_result   :
                                                            ex.rs2_val;

    assign op_a = ex.ctrl.src_a_pc ? ex.pc : rs1_fwd;
    assign op_b = ex.ctrl.jmp       ? 32'd4  :
                  ex.ctrl.src_b_imm ? ex.imm : rs2_fwd;

    always_comb begin
        case (ex.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // BEQ and BNE only
    assign take = ex.ctrl.bra && ((rs1_fwd == rs2_fwd) != ex.ctrl.bra_ne);

    assign target_sum = (ex.ctrl.jalr ? rs1_fwd : ex.pc) + ex.imm;
    assign jump_addr  = {target_sum[31:1], target_sum[0] & ~ex.ctrl.jalr};

    always_ff @(posedge i_clk) begin
        if (i_reset || fb.redirect) begin
            mb.ctrl <= '0;
            mb.take <= 1'b0;
        end else if (!fb.mem_stall) begin
            mb.ctrl <= ex.ctrl;
            mb.take <= take;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!fb.mem_stall) begin
            mb.alu_out   <= alu_res;
            mb.store_val <= rs2_fwd;
            mb.rd_addr   <= ex.rd_addr;
            mb.jump_addr <= jump_addr;
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
/* Fetch and decode: PC, instruction register, decoder, immediate
   generator, register file and load-use hazard detection */
`default_nettype none

module decode_stage #(
    parameter rv_isa_pkg::word_t PC_START   = '0,
    parameter int                REG_ADDR_W = 5
) (
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire rv_isa_pkg::word_t i_instr,
    input  wire logic              i_if_valid,
    output rv_isa_pkg::word_t      o_pc,
    exec_bus_if.producer           ex,
    wb_fwd_if.decode               fb
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t                 pc;
    word_t                 pc_q;
    instr_t                ir;
    ctrl_t                 ctrl;
    word_t                 imm;
    word_t                 regs [2**REG_ADDR_W];
    word_t                 rs1_rd;
    word_t                 rs2_rd;
    word_t                 rs1_hold;
    word_t                 rs2_hold;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [REG_ADDR_W-1:0] wb_idx;
    logic                  load_hazard;
    logic                  decode_hold;

    function automatic alu_op_e alu_from_f3(input logic [2:0] funct3, input logic sub);
        case (funct3)
            F3_ADD_SUB: alu_from_f3 = sub ? ALU_SUB : ALU_ADD;
            F3_XOR:     alu_from_f3 = ALU_XOR;
            F3_OR:      alu_from_f3 = ALU_OR;
            F3_AND:     alu_from_f3 = ALU_AND;
            F3_SLT:     alu_from_f3 = ALU_SLT;
            default:    alu_from_f3 = ALU_ADD;
        endcase
    endfunction

    assign o_pc    = pc;
    assign rs1_idx = ir.rs1[REG_ADDR_W-1:0];
    assign rs2_idx = ir.rs2[REG_ADDR_W-1:0];
    assign wb_idx  = fb.wb_rd[REG_ADDR_W-1:0];

    // Load in execute feeding the instruction being decoded
    assign load_hazard = ex.ctrl.mem2reg &&
                         ((ir.rs1 == ex.rd_addr) || (ir.rs2 == ex.rd_addr));
    assign decode_hold = fb.mem_stall || load_hazard;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= PC_START;
        end else if (fb.redirect) begin
            pc <= fb.redirect_pc;
        end else if (!decode_hold && i_if_valid) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || fb.redirect) begin
            ir <= NOP_INSTR;
        end else if (!decode_hold) begin
            ir <= i_if_valid ? i_instr : NOP_INSTR;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!decode_hold && i_if_valid) begin
            pc_q <= pc;
        end
    end

    always_comb begin
        ctrl = '0;
        case (ir.opcode)
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_w     = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = alu_from_f3(ir.funct3, 1'b0);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_w     = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op = alu_from_f3(ir.funct3, ir.funct7[5]);
                ctrl.reg_w  = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_w     = 1'b1;
                ctrl.mem2reg   = 1'b1;
            end
            OPC_STORE: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_w     = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.bra    = 1'b1;
                ctrl.bra_ne = (ir.funct3 == F3_BNE);
            end
            // Link value is PC + 4 through the ALU
            OPC_JAL, OPC_JALR: begin
                ctrl.src_a_pc = 1'b1;
                ctrl.reg_w    = 1'b1;
                ctrl.jmp      = 1'b1;
                ctrl.jalr     = (ir.opcode == OPC_JALR);
            end
            default: ;
        endcase
        // x0 is never written
        if (ir.rd[REG_ADDR_W-1:0] == '0) begin
            ctrl.reg_w = 1'b0;
        end
    end

    always_comb begin
        case (ir.opcode)
            OPC_LUI:    imm = {ir[31:12], 12'b0};
            OPC_STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_JAL:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:    imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (fb.wb_reg_w && wb_idx != '0) begin
            regs[wb_idx] <= fb.wb_result;
        end
    end

    // Same-cycle writeback bypasses the array
    assign rs1_rd = (fb.wb_reg_w && wb_idx == rs1_idx) ? fb.wb_result :
                    (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_rd = (fb.wb_reg_w && wb_idx == rs2_idx) ? fb.wb_result :
                    (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // While held, pick up the writeback that execute can no longer forward
    assign rs1_hold = (fb.wb_reg_w && wb_idx == ex.rs1_addr[REG_ADDR_W-1:0]) ?
                      fb.wb_result : ex.rs1_val;
    assign rs2_hold = (fb.wb_reg_w && wb_idx == ex.rs2_addr[REG_ADDR_W-1:0]) ?
                      fb.wb_result : ex.rs2_val;

    always_ff @(posedge i_clk) begin
        if (i_reset || fb.redirect) begin
            ex.ctrl <= '0;
        end else if (!fb.mem_stall) begin
            ex.ctrl <= load_hazard ? '0 : ctrl;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fb.mem_stall) begin
            ex.rs1_val <= rs1_hold;
            ex.rs2_val <= rs2_hold;
        end else begin
            ex.pc       <= pc_q;
            ex.rs1_val  <= rs1_rd;
            ex.rs2_val  <= rs2_rd;
            ex.imm      <= imm;
            ex.rs1_addr <= ir.rs1;
            ex.rs2_addr <= ir.rs2;
            ex.rd_addr  <= ir.rd;
        end
    end

endmodule

`default_nettype wire

// File: core_stage_if.sv
/* Pipeline buses: decode to execute, execute to memory,
   and the forwarding and control return path */
`default_nettype none

interface exec_bus_if;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t     ctrl;
    word_t     pc;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;

    modport producer(output ctrl, pc, rs1_val, rs2_val, imm, rs1_addr, rs2_addr, rd_addr);
    modport consumer(input ctrl, pc, rs1_val, rs2_val, imm, rs1_addr, rs2_addr, rd_addr);
endinterface

interface mem_bus_if;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t     ctrl;
    word_t     alu_out;
    word_t     store_val;
    reg_addr_t rd_addr;
    word_t     jump_addr;
    logic      take;

    modport producer(output ctrl, alu_out, store_val, rd_addr, jump_addr, take);
    modport consumer(input ctrl, alu_out, store_val, rd_addr, jump_addr, take);
endinterface

interface wb_fwd_if;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic      mem_reg_w;
    reg_addr_t mem_rd;
    word_t     mem_alu_out;
    logic      wb_reg_w;
    reg_addr_t wb_rd;
    word_t     wb_result;
    logic      redirect;
    word_t     redirect_pc;
    logic      mem_stall;

    modport mem(output mem_reg_w, mem_rd, mem_alu_out, wb_reg_w, wb_rd, wb_result,
                redirect, redirect_pc, mem_stall);
    modport execute(input mem_reg_w, mem_rd, mem_alu_out, wb_reg_w, wb_rd, wb_result,
                    redirect, mem_stall);
    modport decode(input wb_reg_w, wb_rd, wb_result, redirect, redirect_pc, mem_stall);
endinterface

`default_nettype wire

// File: core_ctrl_pkg.sv
/* Core control definitions: ALU operations, register index type
   and the decoded control bundle */
`default_nettype none

package core_ctrl_pkg;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    src_a_pc;
        logic    src_b_imm;
        logic    reg_w;
        logic    mem_w;
        logic    mem2reg;
        logic    bra;
        logic    bra_ne;
        logic    jmp;
        logic    jalr;
    } ctrl_t;

endpackage

`default_nettype wire

// File: rv_isa_pkg.sv
/* RV32 base ISA definitions: word type, major opcodes, funct3 codes,
   instruction field layout and the canonical NOP */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // R-type view shared by the other formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
